/* opreq_top.f */
+incdir+common
common/opreq_pkg.sv
hw/result_write_stage.sv
hw/operand_fetch_unit.sv
arbiter/vrf_bank_arbiter.sv
hw/opreq_top.sv
tb/clk_rst_gen.sv
tb/opreq_sva.sv
tb/opreq_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = opreq_tb
FILELIST = opreq_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/opreq_tb.sv */
// Directed testbench of the operand requester, runs each scenario on the top level and reports
`include "opreq_params.svh"

module opreq_tb import opreq_pkg::*; ();

  localparam int DRIVE_DELAY = 10;
  localparam int TIMEOUT     = 200;

  typedef struct packed {
    opqueue_e tgt;
    vaddr_t   addr;
  } rd_rec_t;

  typedef struct packed {
    logic [1:0] bank;
    vrow_t      row;
    elen_t      wdata;
    strb_t      be;
  } wr_rec_t;

  logic                        clk;
  logic                        rst_n;
  opreq_cmd_t  [`NR_OPQ-1:0]   opreq_cmd;
  logic        [`NR_OPQ-1:0]   opreq_valid;
  logic        [`NR_OPQ-1:0]   opreq_ready;
  logic        [`NR_VINSN-1:0] vinsn_running;
  logic        [`NR_OPQ-1:0]   queue_ready;
  logic        [`NR_OPQ-1:0]   operand_issued;
  logic                        alu_req;
  result_req_t                 alu_result;
  logic                        alu_gnt;
  logic                        ldu_req;
  result_req_t                 ldu_result;
  logic                        ldu_gnt;
  logic        [`NR_BANKS-1:0] vrf_req;
  vrf_req_t    [`NR_BANKS-1:0] vrf_bank;

  rd_rec_t rd_log[$];
  wr_rec_t wr_log[$];
  int      issued_cnt[`NR_OPQ];
  int      err_cnt;
  int      test_err;
  int      tests_run;
  int      tests_failed;
  int      seed;

  clk_rst_gen i_clk_rst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  opreq_top i_dut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .opreq_cmd_i           (opreq_cmd),
    .opreq_valid_i         (opreq_valid),
    .opreq_ready_o         (opreq_ready),
    .vinsn_running_i       (vinsn_running),
    .operand_queue_ready_i (queue_ready),
    .operand_issued_o      (operand_issued),
    .alu_req_i             (alu_req),
    .alu_result_i          (alu_result),
    .alu_gnt_o             (alu_gnt),
    .ldu_req_i             (ldu_req),
    .ldu_result_i          (ldu_result),
    .ldu_gnt_o             (ldu_gnt),
    .vrf_req_o             (vrf_req),
    .vrf_bank_o            (vrf_bank)
  );

  //////////////////////////////////////////////////////////////////////
  // Bank monitor, sampled mid-cycle where outputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    rd_rec_t rd_rec;
    wr_rec_t wr_rec;
    if (rst_n) begin
      for (int b = 0; b < `NR_BANKS; b++) begin
        if (vrf_req[b] && vrf_bank[b].wen) begin
          wr_rec.bank  = 2'(b);
          wr_rec.row   = vrf_bank[b].row;
          wr_rec.wdata = vrf_bank[b].wdata;
          wr_rec.be    = vrf_bank[b].be;
          wr_log.push_back(wr_rec);
        end else if (vrf_req[b]) begin
          rd_rec.tgt  = vrf_bank[b].tgt;
          rd_rec.addr = vaddr_t'(int'(vrf_bank[b].row) * `NR_BANKS + b);
          rd_log.push_back(rd_rec);
        end
      end
      for (int q = 0; q < `NR_OPQ; q++) begin
        if (operand_issued[q]) issued_cnt[q]++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic report_fail(input string what);
    $display("%s", what);
    err_cnt++;
    test_err++;
  endtask

  task automatic start_test();
    test_err = 0;
    rd_log.delete();
    wr_log.delete();
    for (int q = 0; q < `NR_OPQ; q++) issued_cnt[q] = 0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_err == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_err);
    end
  endtask

  // Words needed for vl elements, 8, 4, 2 or 1 per 64-bit word
  function automatic int words_for(input eew_e eew, input vlen_t vl);
    int elems;
    elems = 8 >> int'(eew);
    return (int'(vl) + elems - 1) / elems;
  endfunction

  task automatic send_cmd(input opqueue_e q, input int vs, input eew_e eew, input vlen_t vl,
                          input logic [`NR_VINSN-1:0] hazard);
    int   cycles;
    logic taken;
    cycles                = 0;
    opreq_cmd[int'(q)].vs     = 5'(vs);
    opreq_cmd[int'(q)].eew    = eew;
    opreq_cmd[int'(q)].vl     = vl;
    opreq_cmd[int'(q)].hazard = hazard;
    opreq_valid[int'(q)]  = 1'b1;
    @(negedge clk);
    while (!opreq_ready[int'(q)] && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    taken = opreq_ready[int'(q)];
    next_cycle();
    opreq_valid[int'(q)] = 1'b0;
    if (!taken) report_fail($sformatf("command for %s was never accepted", q.name()));
  endtask

  task automatic wait_ready(input opqueue_e q);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!opreq_ready[int'(q)] && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (!opreq_ready[int'(q)]) begin
      report_fail($sformatf("%s never returned to ready", q.name()));
    end
    next_cycle();
  endtask

  task automatic wait_issued(input opqueue_e q, input int n);
    int cycles;
    cycles = 0;
    while (issued_cnt[int'(q)] < n && cycles < TIMEOUT) begin
      cycles++;
      next_cycle();
    end
    if (issued_cnt[int'(q)] < n) begin
      report_fail($sformatf("%s stopped short of %0d reads", q.name(), n));
    end
  endtask

  task automatic wait_writes(input int n);
    int cycles;
    cycles = 0;
    while (wr_log.size() < n && cycles < TIMEOUT) begin
      cycles++;
      next_cycle();
    end
    if (wr_log.size() < n) report_fail($sformatf("fewer than %0d writes reached the VRF", n));
  endtask

  // Checks the write on bank addr mod NR_BANKS during the grant cycle
  task automatic alu_write(input vid_t id, input vaddr_t addr, input elen_t wdata, input strb_t be);
    int   cycles;
    int   b;
    logic granted;
    cycles           = 0;
    b                = int'(addr) % `NR_BANKS;
    alu_req          = 1'b1;
    alu_result.id    = id;
    alu_result.addr  = addr;
    alu_result.wdata = wdata;
    alu_result.be    = be;
    @(negedge clk);
    while (!alu_gnt && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    granted = alu_gnt;
    if (granted) begin
      check_value("vrf_req_o", 64'(vrf_req[b]), 64'(1));
      check_value("vrf_bank_o.wen", 64'(vrf_bank[b].wen), 64'(1));
      check_value("vrf_bank_o.row", 64'(vrf_bank[b].row), 64'(int'(addr) / `NR_BANKS));
      check_value("vrf_bank_o.wdata", vrf_bank[b].wdata, wdata);
      check_value("vrf_bank_o.be", 64'(vrf_bank[b].be), 64'(be));
      check_value("vrf_bank_o.tgt", 64'(vrf_bank[b].tgt), 64'(0));
    end
    next_cycle();
    alu_req = 1'b0;
    if (!granted) report_fail("ALU write port was never granted");
  endtask

  task automatic ldu_write(input vid_t id, input vaddr_t addr, input elen_t wdata, input strb_t be);
    int   cycles;
    logic granted;
    cycles           = 0;
    ldu_req          = 1'b1;
    ldu_result.id    = id;
    ldu_result.addr  = addr;
    ldu_result.wdata = wdata;
    ldu_result.be    = be;
    @(negedge clk);
    while (!ldu_gnt && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    granted = ldu_gnt;
    next_cycle();
    ldu_req = 1'b0;
    if (!granted) report_fail("load-unit write port was never granted");
  endtask

  // Reads of one queue must walk the register word by word from its base
  task automatic check_reads(input opqueue_e q, input int vs, input int n);
    int     k;
    vaddr_t base;
    k    = 0;
    base = vaddr_t'(vs * `VREG_WORDS);
    foreach (rd_log[i]) begin
      if (rd_log[i].tgt == q) begin
        check_value($sformatf("vrf_bank_o read address for %s", q.name()),
                    64'(rd_log[i].addr), 64'(base + vaddr_t'(k)));
        k++;
      end
    end
    check_value($sformatf("vrf_bank_o read count for %s", q.name()), 64'(k), 64'(n));
    check_value("operand_issued_o count", 64'(issued_cnt[int'(q)]), 64'(n));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_sequential_read();
    start_test();
    send_cmd(OPQ_ALU_A, 3, EW32, 8'd5, '0);
    wait_ready(OPQ_ALU_A);
    check_reads(OPQ_ALU_A, 3, words_for(EW32, 8'd5));
    check_value("vrf_req_o read count", 64'(rd_log.size()), 64'(words_for(EW32, 8'd5)));
    check_value("opreq_ready_o", 64'(opreq_ready[int'(OPQ_ALU_A)]), 64'(1));
    finish_test("sequential_read");
  endtask

  task automatic test_back_pressure();
    start_test();
    queue_ready[int'(OPQ_ALU_B)] = 1'b0;
    send_cmd(OPQ_ALU_B, 5, EW64, 8'd4, '0);
    repeat (20) next_cycle();
    check_value("vrf_req_o read count", 64'(rd_log.size()), 64'(0));
    check_value("operand_issued_o count", 64'(issued_cnt[int'(OPQ_ALU_B)]), 64'(0));
    queue_ready[int'(OPQ_ALU_B)] = 1'b1;
    wait_ready(OPQ_ALU_B);
    check_reads(OPQ_ALU_B, 5, words_for(EW64, 8'd4));
    finish_test("back_pressure");
  endtask

  task automatic test_result_writes();
    elen_t alu_data;
    elen_t ldu_data;
    start_test();
    alu_data = {$random(seed), $random(seed)};
    ldu_data = {$random(seed), $random(seed)};
    alu_write(3'd1, 8'h2d, alu_data, 8'hf0);
    check_value("vrf_req_o write count", 64'(wr_log.size()), 64'(1));
    wr_log.delete();
    ldu_write(3'd4, 8'h36, ldu_data, 8'h0f);
    // Stored first, so nothing reaches a bank in the grant cycle
    check_value("vrf_req_o write count", 64'(wr_log.size()), 64'(0));
    wait_writes(1);
    repeat (5) next_cycle();
    check_value("vrf_req_o write count", 64'(wr_log.size()), 64'(1));
    if (wr_log.size() > 0) begin
      check_value("vrf_bank_o bank", 64'(wr_log[0].bank), 64'(8'h36 % `NR_BANKS));
      check_value("vrf_bank_o.row", 64'(wr_log[0].row), 64'(8'h36 / `NR_BANKS));
      check_value("vrf_bank_o.wdata", wr_log[0].wdata, ldu_data);
      check_value("vrf_bank_o.be", 64'(wr_log[0].be), 64'(8'h0f));
    end
    finish_test("result_writes");
  endtask

  task automatic test_write_priority();
    start_test();
    // A stream of ALU writes keeps bank 0 busy
    alu_req          = 1'b1;
    alu_result.id    = 3'd0;
    alu_result.addr  = 8'h04;
    alu_result.wdata = 64'h0bad_cafe_0000_0004;
    alu_result.be    = 8'hff;
    send_cmd(OPQ_STORE, 0, EW64, 8'd3, '0);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_value("alu_gnt_o", 64'(alu_gnt), 64'(1));
      check_value("operand_issued_o[STORE]", 64'(operand_issued[int'(OPQ_STORE)]), 64'(0));
      check_value("vrf_bank_o[0].wen", 64'(vrf_bank[0].wen), 64'(1));
      next_cycle();
    end
    alu_req = 1'b0;
    wait_ready(OPQ_STORE);
    check_reads(OPQ_STORE, 0, words_for(EW64, 8'd3));
    check_value("vrf_req_o write count", 64'(wr_log.size()), 64'(6));
    finish_test("write_priority");
  endtask

  task automatic test_hazard_stall();
    start_test();
    vinsn_running[2] = 1'b1;
    send_cmd(OPQ_MASK, 2, EW16, 8'd16, 8'h04);
    repeat (20) next_cycle();
    check_value("operand_issued_o count", 64'(issued_cnt[int'(OPQ_MASK)]), 64'(0));
    // Each write of id 2 frees exactly one read
    for (int k = 1; k <= 2; k++) begin
      alu_write(3'd2, 8'h83, {$random(seed), $random(seed)}, 8'hff);
      wait_issued(OPQ_MASK, k);
      repeat (3) next_cycle();
      check_value("operand_issued_o count", 64'(issued_cnt[int'(OPQ_MASK)]), 64'(k));
    end
    vinsn_running[2] = 1'b0;
    wait_ready(OPQ_MASK);
    check_reads(OPQ_MASK, 2, words_for(EW16, 8'd16));
    finish_test("hazard_stall");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int cycles;
    opreq_cmd     = '0;
    opreq_valid   = '0;
    vinsn_running = '0;
    queue_ready   = '1;
    alu_req       = 1'b0;
    alu_result    = '0;
    ldu_req       = 1'b0;
    ldu_result    = '0;
    err_cnt       = 0;
    test_err      = 0;
    tests_run     = 0;
    tests_failed  = 0;
    seed          = 39;
    cycles        = 0;
    while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
      cycles++;
      @(posedge clk);
    end
    if (rst_n !== 1'b1) report_fail("reset was never released");
    next_cycle();

    test_sequential_read();
    test_back_pressure();
    test_result_writes();
    test_write_priority();
    test_hazard_stall();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Last resort if a wait loop itself gets stuck
  initial begin
    #1000000;
    $display("simulation did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* tb/opreq_sva.sv */
// Concurrent checks on the operand requester outputs, bound into the top level for simulation
`include "opreq_params.svh"

module opreq_sva import opreq_pkg::*; (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic        [`NR_OPQ-1:0]   operand_issued_o,
  input logic                        alu_req_i,
  input logic                        alu_gnt_o,
  input logic        [`NR_BANKS-1:0] vrf_req_o,
  input vrf_req_t    [`NR_BANKS-1:0] vrf_bank_o
);

  // Banks stay quiet while reset is held
  no_access_in_reset: assert property (@(posedge clk_i) !rst_ni |-> (vrf_req_o == '0))
    else $error("VRF bank access while reset is asserted");

  // Every read lands on the queue that sees the issued pulse
  for (genvar b = 0; b < `NR_BANKS; b++) begin : gen_bank
    read_target_issued: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (vrf_req_o[b] && !vrf_bank_o[b].wen) |-> operand_issued_o[vrf_bank_o[b].tgt])
      else $error("read on bank %0d without an issued pulse for its target queue", b);
  end

  alu_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_gnt_o |-> alu_req_i)
    else $error("ALU grant without an ALU request");

endmodule

bind opreq_top opreq_sva i_sva (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .operand_issued_o (operand_issued_o),
  .alu_req_i        (alu_req_i),
  .alu_gnt_o        (alu_gnt_o),
  .vrf_req_o        (vrf_req_o),
  .vrf_bank_o       (vrf_bank_o)
);

/* tb/clk_rst_gen.sv */
// Testbench clock and active-low reset source, instantiated once by the testbench top module
module clk_rst_gen #(
  parameter int unsigned PERIOD     = 100,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release a little after the edge, like every other driven input
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #(PERIOD / 10);
    rst_no = 1'b1;
  end

endmodule

/* hw/opreq_top.sv */
// Operand requester of one vector lane, connecting fetch units and result writes to the VRF banks
`include "opreq_params.svh"

module opreq_top import opreq_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Lane sequencer commands, one per operand queue
  input  opreq_cmd_t  [`NR_OPQ-1:0]   opreq_cmd_i,
  input  logic        [`NR_OPQ-1:0]   opreq_valid_i,
  output logic        [`NR_OPQ-1:0]   opreq_ready_o,
  input  logic        [`NR_VINSN-1:0] vinsn_running_i,
  // Operand queues
  input  logic        [`NR_OPQ-1:0]   operand_queue_ready_i,
  output logic        [`NR_OPQ-1:0]   operand_issued_o,
  // Result ports
  input  logic                        alu_req_i,
  input  result_req_t                 alu_result_i,
  output logic                        alu_gnt_o,
  input  logic                        ldu_req_i,
  input  result_req_t                 ldu_result_i,
  output logic                        ldu_gnt_o,
  // VRF banks
  output logic        [`NR_BANKS-1:0] vrf_req_o,
  output vrf_req_t    [`NR_BANKS-1:0] vrf_bank_o
);

  logic        [1:0]           wr_req;
  result_req_t [1:0]           wr_result;
  logic        [1:0]           wr_gnt;
  logic        [`NR_VINSN-1:0] vinsn_written;
  logic        [`NR_OPQ-1:0]   rd_req;
  vaddr_t      [`NR_OPQ-1:0]   rd_addr;
  logic        [`NR_OPQ-1:0]   rd_gnt;

  result_write_stage i_write_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .alu_req_i       (alu_req_i),
    .alu_result_i    (alu_result_i),
    .alu_gnt_o       (alu_gnt_o),
    .ldu_req_i       (ldu_req_i),
    .ldu_result_i    (ldu_result_i),
    .ldu_gnt_o       (ldu_gnt_o),
    .wr_req_o        (wr_req),
    .wr_result_o     (wr_result),
    .wr_gnt_i        (wr_gnt),
    .vinsn_written_o (vinsn_written)
  );

  // One fetch unit per operand queue
  for (genvar i = 0; i < `NR_OPQ; i++) begin : gen_fetch
    operand_fetch_unit i_fetch (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .cmd_i           (opreq_cmd_i[i]),
      .cmd_valid_i     (opreq_valid_i[i]),
      .cmd_ready_o     (opreq_ready_o[i]),
      .vinsn_running_i (vinsn_running_i),
      .vinsn_written_i (vinsn_written),
      .queue_ready_i   (operand_queue_ready_i[i]),
      .rd_req_o        (rd_req[i]),
      .rd_addr_o       (rd_addr[i]),
      .rd_gnt_i        (rd_gnt[i]),
      .issued_o        (operand_issued_o[i])
    );
  end

  vrf_bank_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_gnt_o    (rd_gnt),
    .wr_req_i    (wr_req),
    .wr_result_i (wr_result),
    .wr_gnt_o    (wr_gnt),
    .vrf_req_o   (vrf_req_o),
    .vrf_bank_o  (vrf_bank_o)
  );

endmodule

/* arbiter/vrf_bank_arbiter.sv */
// Per-bank VRF arbiter, high class masks low class with round robin inside each class
`include "opreq_params.svh"

module vrf_bank_arbiter import opreq_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Reads from the fetch units
  input  logic        [`NR_OPQ-1:0]   rd_req_i,
  input  vaddr_t      [`NR_OPQ-1:0]   rd_addr_i,
  output logic        [`NR_OPQ-1:0]   rd_gnt_o,
  // Writes from the write stage, port 0 ALU and port 1 load unit
  input  logic        [1:0]           wr_req_i,
  input  result_req_t [1:0]           wr_result_i,
  output logic        [1:0]           wr_gnt_o,
  // VRF banks
  output logic        [`NR_BANKS-1:0] vrf_req_o,
  output vrf_req_t    [`NR_BANKS-1:0] vrf_bank_o
);

  localparam int unsigned BANK_W = $clog2(`NR_BANKS);

  // Round-robin pointers per bank and class
  logic [`NR_BANKS-1:0][1:0][1:0] rr_d;
  logic [`NR_BANKS-1:0][1:0][1:0] rr_q;

  // First requester at or after the pointer, wrapping over three slots
  function automatic logic [1:0] rr_pick(input logic [2:0] req, input logic [1:0] ptr);
    logic [1:0] idx;
    logic       found;
    found   = 1'b0;
    rr_pick = ptr;
    for (int k = 0; k < 3; k++) begin
      idx = (int'(ptr) + k >= 3) ? 2'(int'(ptr) + k - 3) : 2'(int'(ptr) + k);
      if (!found && req[idx]) begin
        rr_pick = idx;
        found   = 1'b1;
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////////////////////////

  // Class c holds reads of queues 2c and 2c+1 in slots 0 and 1,
  // and write port c in slot 2
  always_comb begin
    logic [1:0][2:0] cls_req;
    logic            cls;
    logic [1:0]      win;
    int              q;

    rd_gnt_o   = '0;
    wr_gnt_o   = '0;
    vrf_req_o  = '0;
    vrf_bank_o = '0;
    rr_d       = rr_q;

    for (int b = 0; b < `NR_BANKS; b++) begin
      for (int c = 0; c < 2; c++) begin
        cls_req[c][0] = rd_req_i[2*c] && (rd_addr_i[2*c][BANK_W-1:0] == BANK_W'(b));
        cls_req[c][1] = rd_req_i[2*c+1] && (rd_addr_i[2*c+1][BANK_W-1:0] == BANK_W'(b));
        cls_req[c][2] = wr_req_i[c] && (wr_result_i[c].addr[BANK_W-1:0] == BANK_W'(b));
      end

      // High class always wins when present
      cls = (|cls_req[0]) ? 1'b0 : 1'b1;
      win = 2'd0;
      q   = 0;

      if (|cls_req[cls]) begin
        win            = rr_pick(cls_req[cls], rr_q[b][cls]);
        rr_d[b][cls]   = (win == 2'd2) ? 2'd0 : win + 2'd1;
        vrf_req_o[b]   = 1'b1;
        if (win == 2'd2) begin
          wr_gnt_o[cls] = 1'b1;
          vrf_bank_o[b] = '{
            row:   wr_result_i[cls].addr[`VADDR_W-1:BANK_W],
            wen:   1'b1,
            wdata: wr_result_i[cls].wdata,
            be:    wr_result_i[cls].be,
            tgt:   OPQ_ALU_A
          };
        end else begin
          q             = 2 * int'(cls) + int'(win);
          rd_gnt_o[q]   = 1'b1;
          vrf_bank_o[b] = '{
            row:   rd_addr_i[q][`VADDR_W-1:BANK_W],
            wen:   1'b0,
            wdata: '0,
            be:    '0,
            tgt:   opqueue_e'(q)
          };
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

endmodule

/* hw/operand_fetch_unit.sv */
// Fetch unit of one operand queue, walks a vector register word by word through the bank arbiter
`include "opreq_params.svh"

module operand_fetch_unit import opreq_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Command from the lane sequencer
  input  opreq_cmd_t           cmd_i,
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  // Hazard tracking
  input  logic [`NR_VINSN-1:0] vinsn_running_i,
  input  logic [`NR_VINSN-1:0] vinsn_written_i,
  // Operand queue back-pressure
  input  logic                 queue_ready_i,
  // Read port towards the bank arbiter
  output logic                 rd_req_o,
  output vaddr_t               rd_addr_o,
  input  logic                 rd_gnt_i,
  output logic                 issued_o
);

  fetch_state_e         state_d;
  fetch_state_e         state_q;
  vaddr_t               addr_d;
  vaddr_t               addr_q;
  vlen_t                len_d;
  vlen_t                len_q;
  eew_e                 eew_d;
  eew_e                 eew_q;
  logic [`NR_VINSN-1:0] hazard_d;
  logic [`NR_VINSN-1:0] hazard_q;

  logic  stall;
  vlen_t elems;
  logic  last_word;

  // Hold off while an earlier instruction skipped its write last cycle
  assign stall = |(hazard_q & ~vinsn_written_i);

  // Elements packed into one 64-bit word
  assign elems     = vlen_t'(1) << (3 - int'(eew_q));
  assign last_word = (len_q <= elems);

  assign rd_req_o  = (state_q == FETCH_ACTIVE) && queue_ready_i && !stall;
  assign rd_addr_o = addr_q;
  assign issued_o  = rd_req_o & rd_gnt_i;

  //////////////////////////////////////////////////////////////////////
  // Next-state logic
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    addr_d      = addr_q;
    len_d       = len_q;
    eew_d       = eew_q;
    hazard_d    = hazard_q;
    cmd_ready_o = 1'b0;

    case (state_q)
      FETCH_IDLE: begin
        cmd_ready_o = 1'b1;
      end
      FETCH_ACTIVE: begin
        // Drop hazards on instructions that have retired
        hazard_d = hazard_q & vinsn_running_i;
        if (issued_o) begin
          addr_d = addr_q + vaddr_t'(1);
          if (last_word) begin
            len_d       = '0;
            state_d     = FETCH_IDLE;
            // Back-to-back commands on the last grant
            cmd_ready_o = 1'b1;
          end else begin
            len_d = len_q - elems;
          end
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase

    if (cmd_ready_o && cmd_valid_i) begin
      // Empty vectors need no reads
      state_d  = (cmd_i.vl != '0) ? FETCH_ACTIVE : FETCH_IDLE;
      addr_d   = vaddr_t'(int'(cmd_i.vs) * `VREG_WORDS);
      len_d    = cmd_i.vl;
      eew_d    = cmd_i.eew;
      hazard_d = cmd_i.hazard;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= FETCH_IDLE;
      hazard_q <= '0;
    end else begin
      state_q  <= state_d;
      hazard_q <= hazard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    len_q  <= len_d;
    eew_q  <= eew_d;
  end

endmodule

/* hw/result_write_stage.sv */
// Result write ports of the lane, feeding ALU and load-unit writes to the VRF bank arbiter
`include "opreq_params.svh"

module result_write_stage import opreq_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // ALU result port
  input  logic                       alu_req_i,
  input  result_req_t                alu_result_i,
  output logic                       alu_gnt_o,
  // Load-unit result port
  input  logic                       ldu_req_i,
  input  result_req_t                ldu_result_i,
  output logic                       ldu_gnt_o,
  // Towards the bank arbiter, port 0 ALU and port 1 load unit
  output logic        [1:0]          wr_req_o,
  output result_req_t [1:0]          wr_result_o,
  input  logic        [1:0]          wr_gnt_i,
  // Instructions that wrote in the previous cycle
  output logic        [`NR_VINSN-1:0] vinsn_written_o
);

  //////////////////////////////////////////////////////////////////////
  // ALU port
  //////////////////////////////////////////////////////////////////////

  // High priority, goes straight to the arbiter
  assign wr_req_o[0]    = alu_req_i;
  assign wr_result_o[0] = alu_result_i;
  assign alu_gnt_o      = wr_gnt_i[0];

  //////////////////////////////////////////////////////////////////////
  // Load-unit stream register
  //////////////////////////////////////////////////////////////////////

  logic        ldu_valid_q;
  result_req_t ldu_data_q;

  // Accept only into an empty slot
  assign ldu_gnt_o = ldu_req_i & ~ldu_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_valid_q <= 1'b0;
    end else if (ldu_gnt_o) begin
      ldu_valid_q <= 1'b1;
    end else if (wr_gnt_i[1]) begin
      ldu_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldu_gnt_o) begin
      ldu_data_q <= ldu_result_i;
    end
  end

  assign wr_req_o[1]    = ldu_valid_q;
  assign wr_result_o[1] = ldu_data_q;

  //////////////////////////////////////////////////////////////////////
  // Written-instruction tracking
  //////////////////////////////////////////////////////////////////////

  logic [`NR_VINSN-1:0] written_d;
  logic [`NR_VINSN-1:0] written_q;

  always_comb begin
    written_d = '0;
    // One bit per instruction id, set by any granted port
    written_d[alu_result_i.id] |= wr_gnt_i[0];
    written_d[ldu_data_q.id]   |= wr_gnt_i[1];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else begin
      written_q <= written_d;
    end
  end

  assign vinsn_written_o = written_q;

endmodule

/* common/opreq_pkg.sv */
// Shared types of the operand requester, imported by every RTL module and the testbench
package opreq_pkg;

`include "opreq_params.svh"

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Element width, a 64-bit word holds 8, 4, 2 or 1 elements
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } eew_e;

  // Operand queues, ALU_A and ALU_B form the high class
  typedef enum logic [1:0] {
    OPQ_ALU_A,
    OPQ_ALU_B,
    OPQ_MASK,
    OPQ_STORE
  } opqueue_e;

  // Fetch unit FSM
  typedef enum logic {
    FETCH_IDLE,
    FETCH_ACTIVE
  } fetch_state_e;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [2:0]                             vid_t;
  typedef logic [`VADDR_W-1:0]                    vaddr_t;
  typedef logic [`VADDR_W-$clog2(`NR_BANKS)-1:0]  vrow_t;
  typedef logic [`VLEN_W-1:0]                     vlen_t;
  typedef logic [`ELEN-1:0]                       elen_t;
  typedef logic [`ELEN/8-1:0]                     strb_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Read request for one vector operand
  typedef struct packed {
    logic [4:0]           vs;
    eew_e                 eew;
    vlen_t                vl;
    logic [`NR_VINSN-1:0] hazard;
  } opreq_cmd_t;

  // Result word to be written back
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_req_t;

  // One access on a VRF bank
  typedef struct packed {
    vrow_t    row;
    logic     wen;
    elen_t    wdata;
    strb_t    be;
    opqueue_e tgt;
  } vrf_req_t;

endpackage

/* common/opreq_params.svh */
// Fixed sizes of the operand requester, included wherever queue, bank or width counts are needed
`ifndef OPREQ_PARAMS_SVH
`define OPREQ_PARAMS_SVH

// Operand queues served by the requester
`define NR_OPQ 4

// Banks of the vector register file
`define NR_BANKS 4

// Instruction ids that can be in flight
`define NR_VINSN 8

// Words of one vector register held in this lane
`define VREG_WORDS 8

// Word address and vector length widths
`define VADDR_W 8
`define VLEN_W 8

// Datapath word width
`define ELEN 64

`endif
